// File: hw/qsim_macros.svh
`ifndef QSIM_MACROS_SVH
`define QSIM_MACROS_SVH

// sram geometry
`define QSIM_ADDR_W 8
`define QSIM_WORD_W 32

// one real or imaginary part, Q4.12
`define QSIM_PART_W 16
`define QSIM_FRAC_BITS 12

// gate size limit, N = 2**Q
`define QSIM_MAX_QUBITS 3

// address issue to registered lane output
`define QSIM_PIPE_DELAY 2

`endif

// File: hw/qsim_pkg.sv
`default_nettype none

`include "qsim_macros.svh"

package qsim_pkg;

  // ------------------------------
  // datapath vectors
  // ------------------------------
  typedef logic [`QSIM_ADDR_W-1:0] addr_t;

  // real part in the upper half, imaginary in the lower
  typedef logic [`QSIM_WORD_W-1:0] word_t;

  typedef logic signed [`QSIM_PART_W-1:0] part_t;

  // qubit count from header bits 1:0
  typedef logic [$clog2(`QSIM_MAX_QUBITS+1)-1:0] qubits_t;

  // ------------------------------
  // sequencer states
  // ------------------------------
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_HEADER,
    SEQ_STREAM,
    SEQ_DRAIN
  } seq_state_t;

endpackage

`default_nettype wire

// File: hw/gate_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "qsim_macros.svh"

module gate_sequencer (
  input  wire logic            clk,
  input  wire logic            reset_n,
  input  wire logic            dut_valid,
  input  wire qsim_pkg::word_t input_sram_read_data,
  output logic                 dut_ready,
  output qsim_pkg::addr_t      input_sram_read_address,
  output qsim_pkg::addr_t      gate_sram_read_address,
  output logic                 run_start,
  output logic                 product_valid,
  output logic                 row_last
);

  localparam int IDX_W  = `QSIM_MAX_QUBITS;
  localparam int ADDR_W = `QSIM_ADDR_W;
  localparam int PIPE_W = `QSIM_PIPE_DELAY;

  localparam qsim_pkg::addr_t HEADER_ADDR = '0;
  localparam qsim_pkg::addr_t AMP_BASE    = 1;

  // lane pipeline, one accumulator register, then the write edge
  localparam logic [2:0] DRAIN_LAST = 3'(`QSIM_PIPE_DELAY + 1);

  qsim_pkg::seq_state_t state;
  qsim_pkg::qubits_t    q_reg;
  qsim_pkg::qubits_t    hdr_q;
  logic                 hdr_wait;
  logic [2:0]           drain_cnt;

  logic [IDX_W-1:0]     row_idx;
  logic [IDX_W-1:0]     col_idx;
  logic [IDX_W-1:0]     row_nx;
  logic [IDX_W-1:0]     col_nx;
  logic [IDX_W-1:0]     n_max;
  logic                 pair_done;
  qsim_pkg::addr_t      row_ext;
  qsim_pkg::addr_t      col_ext;

  logic                 issue_valid;
  logic                 issue_last;
  logic [PIPE_W-1:0]    valid_pipe;
  logic [PIPE_W-1:0]    last_pipe;

  assign dut_ready = (state == qsim_pkg::SEQ_IDLE);
  assign hdr_q     = input_sram_read_data[$bits(qsim_pkg::qubits_t)-1:0];

  // ------------------------------
  // next (row, col) pair
  // ------------------------------
  always_comb begin
    // N-1 as a mask
    n_max     = ~({IDX_W{1'b1}} << q_reg);
    pair_done = (row_idx == n_max) && (col_idx == n_max);
    if (col_idx == n_max) begin
      col_nx = '0;
      row_nx = row_idx + 1'b1;
    end else begin
      col_nx = col_idx + 1'b1;
      row_nx = row_idx;
    end
  end

  assign row_ext = {{(ADDR_W-IDX_W){1'b0}}, row_nx};
  assign col_ext = {{(ADDR_W-IDX_W){1'b0}}, col_nx};

  // ------------------------------
  // fsm and address registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state                   <= qsim_pkg::SEQ_IDLE;
      hdr_wait                <= 1'b0;
      q_reg                   <= '0;
      row_idx                 <= '0;
      col_idx                 <= '0;
      drain_cnt               <= '0;
      input_sram_read_address <= HEADER_ADDR;
      gate_sram_read_address  <= '0;
      run_start               <= 1'b0;
      issue_valid             <= 1'b0;
      issue_last              <= 1'b0;
    end else begin
      run_start   <= 1'b0;
      issue_valid <= 1'b0;
      issue_last  <= 1'b0;
      case (state)
        qsim_pkg::SEQ_IDLE: begin
          if (dut_valid) begin
            state                   <= qsim_pkg::SEQ_HEADER;
            hdr_wait                <= 1'b1;
            input_sram_read_address <= HEADER_ADDR;
            run_start               <= 1'b1;
          end
        end
        qsim_pkg::SEQ_HEADER: begin
          // one cycle for the sram to return the header word
          if (hdr_wait) begin
            hdr_wait <= 1'b0;
          end else begin
            q_reg                   <= hdr_q;
            row_idx                 <= '0;
            col_idx                 <= '0;
            input_sram_read_address <= AMP_BASE;
            gate_sram_read_address  <= '0;
            issue_valid             <= 1'b1;
            issue_last              <= (hdr_q == '0);
            state                   <= qsim_pkg::SEQ_STREAM;
          end
        end
        qsim_pkg::SEQ_STREAM: begin
          if (pair_done) begin
            state     <= qsim_pkg::SEQ_DRAIN;
            drain_cnt <= '0;
          end else begin
            row_idx                 <= row_nx;
            col_idx                 <= col_nx;
            input_sram_read_address <= AMP_BASE + col_ext;
            gate_sram_read_address  <= (row_ext << q_reg) + col_ext;
            issue_valid             <= 1'b1;
            issue_last              <= (col_nx == n_max);
          end
        end
        qsim_pkg::SEQ_DRAIN: begin
          if (drain_cnt == DRAIN_LAST) begin
            state <= qsim_pkg::SEQ_IDLE;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        default: state <= qsim_pkg::SEQ_IDLE;
      endcase
    end
  end

  // align flags with the registered lane outputs
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_pipe <= '0;
      last_pipe  <= '0;
    end else begin
      valid_pipe <= {valid_pipe[PIPE_W-2:0], issue_valid};
      last_pipe  <= {last_pipe[PIPE_W-2:0], issue_last};
    end
  end

  assign product_valid = valid_pipe[PIPE_W-1];
  assign row_last      = last_pipe[PIPE_W-1];

endmodule

`default_nettype wire

// File: hw/cmul_real_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "qsim_macros.svh"

module cmul_real_lane (
  input  wire logic            clk,
  input  wire logic            reset_n,
  input  wire qsim_pkg::word_t state_word,
  input  wire qsim_pkg::word_t gate_word,
  output qsim_pkg::part_t      real_part
);

  localparam int PART_W = `QSIM_PART_W;
  localparam int WORD_W = `QSIM_WORD_W;

  qsim_pkg::part_t ar;
  qsim_pkg::part_t ai;
  qsim_pkg::part_t br;
  qsim_pkg::part_t bi;

  logic signed [2*PART_W-1:0] prod_rr;
  logic signed [2*PART_W-1:0] prod_ii;
  qsim_pkg::part_t            term_rr;
  qsim_pkg::part_t            term_ii;

  // unpack, state is a, gate is b
  assign ar = state_word[WORD_W-1 -: PART_W];
  assign ai = state_word[PART_W-1:0];
  assign br = gate_word[WORD_W-1 -: PART_W];
  assign bi = gate_word[PART_W-1:0];

  assign prod_rr = ar * br;
  assign prod_ii = ai * bi;

  // arithmetic shift then truncate is just a bit slice
  assign term_rr = prod_rr[`QSIM_FRAC_BITS +: PART_W];
  assign term_ii = prod_ii[`QSIM_FRAC_BITS +: PART_W];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      real_part <= '0;
    end else begin
      real_part <= term_rr - term_ii;
    end
  end

endmodule

`default_nettype wire

// File: hw/cmul_imag_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "qsim_macros.svh"

module cmul_imag_lane (
  input  wire logic            clk,
  input  wire logic            reset_n,
  input  wire qsim_pkg::word_t state_word,
  input  wire qsim_pkg::word_t gate_word,
  output qsim_pkg::part_t      imag_part
);

  localparam int PART_W = `QSIM_PART_W;
  localparam int WORD_W = `QSIM_WORD_W;

  qsim_pkg::part_t ar;
  qsim_pkg::part_t ai;
  qsim_pkg::part_t br;
  qsim_pkg::part_t bi;

  logic signed [2*PART_W-1:0] prod_ri;
  logic signed [2*PART_W-1:0] prod_ir;
  qsim_pkg::part_t            term_ri;
  qsim_pkg::part_t            term_ir;

  assign ar = state_word[WORD_W-1 -: PART_W];
  assign ai = state_word[PART_W-1:0];
  assign br = gate_word[WORD_W-1 -: PART_W];
  assign bi = gate_word[PART_W-1:0];

  // cross products
  assign prod_ri = ar * bi;
  assign prod_ir = ai * br;

  // back to Q4.12, wraps mod 2^16
  assign term_ri = prod_ri[`QSIM_FRAC_BITS +: PART_W];
  assign term_ir = prod_ir[`QSIM_FRAC_BITS +: PART_W];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      imag_part <= '0;
    end else begin
      imag_part <= term_ri + term_ir;
    end
  end

endmodule

`default_nettype wire

// File: hw/amplitude_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module amplitude_accumulator (
  input  wire logic            clk,
  input  wire logic            reset_n,
  input  wire logic            run_start,
  input  wire logic            product_valid,
  input  wire logic            row_last,
  input  wire qsim_pkg::part_t real_part,
  input  wire qsim_pkg::part_t imag_part,
  output logic                 output_sram_write_enable,
  output qsim_pkg::addr_t      output_sram_write_address,
  output qsim_pkg::word_t      output_sram_write_data
);

  qsim_pkg::part_t sum_re;
  qsim_pkg::part_t sum_im;
  qsim_pkg::part_t next_re;
  qsim_pkg::part_t next_im;
  qsim_pkg::addr_t out_row;

  // running sums, wrap per part
  assign next_re = sum_re + real_part;
  assign next_im = sum_im + imag_part;

  assign output_sram_write_address = out_row;

  // ------------------------------
  // sums, write strobe, row count
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      sum_re                   <= '0;
      sum_im                   <= '0;
      out_row                  <= '0;
      output_sram_write_enable <= 1'b0;
    end else begin
      output_sram_write_enable <= product_valid && row_last;
      if (run_start) begin
        out_row <= '0;
      end else if (output_sram_write_enable) begin
        out_row <= out_row + 1'b1;
      end
      if (product_valid) begin
        // next row starts from zero on the very next product
        if (row_last) begin
          sum_re <= '0;
          sum_im <= '0;
        end else begin
          sum_re <= next_re;
          sum_im <= next_im;
        end
      end
    end
  end

  // finished amplitude, real part high
  always_ff @(posedge clk) begin
    if (product_valid && row_last) begin
      output_sram_write_data <= {next_re, next_im};
    end
  end

endmodule

`default_nettype wire

// File: hw/qsim_top.sv
`timescale 1ns/1ps
`default_nettype none

module qsim_top (
  input  wire logic            clk,
  input  wire logic            reset_n,

  // start handshake
  input  wire logic            dut_valid,
  output wire logic            dut_ready,

  // input state sram, word 0 is the header
  output wire qsim_pkg::addr_t input_sram_read_address,
  input  wire qsim_pkg::word_t input_sram_read_data,

  // gate sram, entry (r,c) at r*N+c
  output wire qsim_pkg::addr_t gate_sram_read_address,
  input  wire qsim_pkg::word_t gate_sram_read_data,

  // output state sram
  output wire logic            output_sram_write_enable,
  output wire qsim_pkg::addr_t output_sram_write_address,
  output wire qsim_pkg::word_t output_sram_write_data
);

  logic            run_start;
  logic            product_valid;
  logic            row_last;
  qsim_pkg::part_t real_part;
  qsim_pkg::part_t imag_part;

  // ------------------------------
  // control and address streaming
  // ------------------------------
  gate_sequencer u_sequencer (
    .clk                     (clk),
    .reset_n                 (reset_n),
    .dut_valid               (dut_valid),
    .input_sram_read_data    (input_sram_read_data),
    .dut_ready               (dut_ready),
    .input_sram_read_address (input_sram_read_address),
    .gate_sram_read_address  (gate_sram_read_address),
    .run_start               (run_start),
    .product_valid           (product_valid),
    .row_last                (row_last)
  );

  // ------------------------------
  // complex multiply, two lanes
  // ------------------------------
  cmul_real_lane u_real_lane (
    .clk        (clk),
    .reset_n    (reset_n),
    .state_word (input_sram_read_data),
    .gate_word  (gate_sram_read_data),
    .real_part  (real_part)
  );

  cmul_imag_lane u_imag_lane (
    .clk        (clk),
    .reset_n    (reset_n),
    .state_word (input_sram_read_data),
    .gate_word  (gate_sram_read_data),
    .imag_part  (imag_part)
  );

  // row sums and output writes
  amplitude_accumulator u_accumulator (
    .clk                       (clk),
    .reset_n                   (reset_n),
    .run_start                 (run_start),
    .product_valid             (product_valid),
    .row_last                  (row_last),
    .real_part                 (real_part),
    .imag_part                 (imag_part),
    .output_sram_write_enable  (output_sram_write_enable),
    .output_sram_write_address (output_sram_write_address),
    .output_sram_write_data    (output_sram_write_data)
  );

endmodule

`default_nettype wire

// File: sim/qsim_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "qsim_macros.svh"

module qsim_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 3;
  localparam int RUN_COUNT    = 5;
  localparam int MEM_DEPTH    = 1 << `QSIM_ADDR_W;
  localparam int WATCHDOG_NS  = RUN_COUNT * (64 + 20) * CLK_PERIOD
                              + RESET_CYCLES * CLK_PERIOD;

  logic                 clk;
  logic                 reset_n;
  logic                 dut_valid;
  wire                  dut_ready;
  wire qsim_pkg::addr_t input_sram_read_address;
  qsim_pkg::word_t      input_sram_read_data = '0;
  wire qsim_pkg::addr_t gate_sram_read_address;
  qsim_pkg::word_t      gate_sram_read_data = '0;
  wire                  output_sram_write_enable;
  wire qsim_pkg::addr_t output_sram_write_address;
  wire qsim_pkg::word_t output_sram_write_data;

  qsim_pkg::word_t in_mem   [MEM_DEPTH];
  qsim_pkg::word_t gate_mem [MEM_DEPTH];
  qsim_pkg::word_t out_mem  [MEM_DEPTH];
  qsim_pkg::addr_t write_addrs [$];
  logic [31:0]     lcg_state;

  qsim_top UUT (
    .clk                       (clk),
    .reset_n                   (reset_n),
    .dut_valid                 (dut_valid),
    .dut_ready                 (dut_ready),
    .input_sram_read_address   (input_sram_read_address),
    .input_sram_read_data      (input_sram_read_data),
    .gate_sram_read_address    (gate_sram_read_address),
    .gate_sram_read_data       (gate_sram_read_data),
    .output_sram_write_enable  (output_sram_write_enable),
    .output_sram_write_address (output_sram_write_address),
    .output_sram_write_data    (output_sram_write_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // sram models
  // ------------------------------
  always @(posedge clk) begin
    input_sram_read_data <= in_mem[input_sram_read_address];
    gate_sram_read_data  <= gate_mem[gate_sram_read_address];
  end

  // log every write in order
  always @(posedge clk) begin
    if (output_sram_write_enable) begin
      out_mem[output_sram_write_address] = output_sram_write_data;
      write_addrs.push_back(output_sram_write_address);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, a run never finished", WATCHDOG_NS);
    $display("Test failures found");
    $fatal(1);
  end

  // ------------------------------
  // helpers and reference model
  // ------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // roughly +-2.0 so that signs mix and sums stay small
  function automatic qsim_pkg::part_t small_part();
    logic [31:0] r;
    r = next_rand();
    return qsim_pkg::part_t'($signed(r[31:16]) >>> 2);
  endfunction

  function automatic qsim_pkg::part_t scaled_mul(qsim_pkg::part_t x, qsim_pkg::part_t y);
    int full;
    full = int'(x) * int'(y);
    full = full >>> `QSIM_FRAC_BITS;
    return qsim_pkg::part_t'(full);
  endfunction

  function automatic qsim_pkg::word_t complex_mul(qsim_pkg::word_t a, qsim_pkg::word_t b);
    qsim_pkg::part_t re;
    qsim_pkg::part_t im;
    re = scaled_mul(a[31:16], b[31:16]) - scaled_mul(a[15:0], b[15:0]);
    im = scaled_mul(a[31:16], b[15:0]) + scaled_mul(a[15:0], b[31:16]);
    return {re, im};
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_word(string name, qsim_pkg::word_t expected, qsim_pkg::word_t actual);
    if (actual !== expected) begin
      $display("** Error %s: expected 0x%08h, got 0x%08h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_addr(string name, qsim_pkg::addr_t expected, qsim_pkg::addr_t actual);
    if (actual !== expected) begin
      $display("** Error %s: expected 0x%02h, got 0x%02h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("** Error %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_count(string name, int expected, int actual);
    if (actual != expected) begin
      $display("** Error %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      abort_run();
    end
  endtask

  // every byte follows the whole address
  task automatic fill_memories(input int q);
    for (int a = 0; a < MEM_DEPTH; a++) begin
      in_mem[a]   = {8'(a), 8'(~a), 8'(a ^ 8'h5a), 8'hc3};
      gate_mem[a] = {8'(~a), 8'(a), 8'hc3, 8'(a ^ 8'ha5)};
      out_mem[a]  = {8'hee, 8'(a), 8'(~a), 8'(a)};
    end
    in_mem[0] = 32'(q);
    write_addrs.delete();
  endtask

  // called 1 ns after an edge with the DUT idle
  task automatic run_gate(input int q, input bit hold_valid);
    int cycles;
    int n;
    n = 1 << q;
    dut_valid = 1'b1;
    @(posedge clk);
    #1;
    if (!hold_valid) begin
      dut_valid = 1'b0;
    end
    check_flag("dut_ready", 1'b0, dut_ready);
    cycles = 0;
    while (!dut_ready) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > n * n + 20) begin
        $display("dut_ready stayed low for %0d cycles after the start", cycles);
        abort_run();
      end
    end
    dut_valid = 1'b0;
    check_count("start to dut_ready cycles", n * n + 6, cycles);
  endtask

  task automatic check_results(input int q);
    int n;
    qsim_pkg::part_t sum_re;
    qsim_pkg::part_t sum_im;
    qsim_pkg::word_t prod;
    n = 1 << q;
    check_count("output write count", n, write_addrs.size());
    for (int r = 0; r < n; r++) begin
      sum_re = '0;
      sum_im = '0;
      for (int c = 0; c < n; c++) begin
        prod = complex_mul(in_mem[1 + c], gate_mem[r * n + c]);
        sum_re += prod[31:16];
        sum_im += prod[15:0];
      end
      check_addr($sformatf("output_sram_write_address #%0d", r), 8'(r), write_addrs[r]);
      check_word($sformatf("output_sram[%0d]", r), {sum_re, sum_im}, out_mem[r]);
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_reset_state();
    check_flag("dut_ready", 1'b1, dut_ready);
    check_flag("output_sram_write_enable", 1'b0, output_sram_write_enable);
    repeat (5) begin
      @(posedge clk);
      #1;
      check_flag("output_sram_write_enable", 1'b0, output_sram_write_enable);
    end
    check_count("output write count", 0, write_addrs.size());
  endtask

  task automatic test_identity_gate();
    fill_memories(1);
    for (int c = 0; c < 2; c++) begin
      in_mem[1 + c] = next_rand();
    end
    for (int i = 0; i < 4; i++) begin
      gate_mem[i] = (i == 0 || i == 3) ? 32'h1000_0000 : 32'h0;
    end
    run_gate(1, 1'b0);
    check_results(1);
    for (int r = 0; r < 2; r++) begin
      check_word($sformatf("output_sram[%0d]", r), in_mem[1 + r], out_mem[r]);
    end
  endtask

  task automatic test_random_gate();
    fill_memories(3);
    for (int c = 0; c < 8; c++) begin
      in_mem[1 + c] = {small_part(), small_part()};
    end
    for (int i = 0; i < 64; i++) begin
      gate_mem[i] = {small_part(), small_part()};
    end
    run_gate(3, 1'b0);
    check_results(3);
  endtask

  // -1.5 - 1lsb*i times 0.5 + 1lsb*i, worked by hand as f401 / fffd
  task automatic test_single_product();
    fill_memories(0);
    in_mem[1]   = {16'he800, 16'hffff};
    gate_mem[0] = {16'h0800, 16'h0001};
    run_gate(0, 1'b0);
    check_results(0);
    check_word("output_sram[0]", 32'hf401_fffd, out_mem[0]);
  endtask

  task automatic test_back_to_back();
    fill_memories(2);
    for (int c = 0; c < 4; c++) begin
      in_mem[1 + c] = next_rand();
    end
    for (int i = 0; i < 16; i++) begin
      gate_mem[i] = next_rand();
    end
    run_gate(2, 1'b1);
    check_results(2);
    // still idle one cycle later, so the held valid did nothing
    @(posedge clk);
    #1;
    check_flag("dut_ready", 1'b1, dut_ready);
    fill_memories(1);
    for (int c = 0; c < 2; c++) begin
      in_mem[1 + c] = next_rand();
    end
    for (int i = 0; i < 4; i++) begin
      gate_mem[i] = {small_part(), small_part()};
    end
    run_gate(1, 1'b0);
    check_results(1);
  endtask

  initial begin
    lcg_state = 32'h2804_d314;
    reset_n   = 1'b0;
    dut_valid = 1'b0;
    fill_memories(0);
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n = 1'b1;
    test_reset_state();
    test_identity_gate();
    test_random_gate();
    test_single_product();
    test_back_to_back();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/qsim_pkg.sv
hw/gate_sequencer.sv
hw/cmul_real_lane.sv
hw/cmul_imag_lane.sv
hw/amplitude_accumulator.sv
hw/qsim_top.sv
sim/qsim_tb.sv

// File: Makefile
# Verilator build and run of the gate testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= qsim_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

# the simulator exits non-zero on $$fatal, so make fails with it
test: $(SIM_BIN)
	./$(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
